// File: cab_inputs.sv
/* cabinet input synchronizer, builds the two port bytes seen by the sound cpu
   index 0/1 of each port is picked by address bit 0 */
`timescale 1ns/10ps

module cab_inputs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [15:0]           dipsw,
    input  logic [ 6:0]           joystick1,
    input  logic [ 6:0]           joystick2,
    input  logic [ 1:0]           coin,
    input  logic                  service,
    input  logic [ 1:0]           cab_1p,
    output snd_pkg::byte_t [1:0]  cab_a,
    output snd_pkg::byte_t [1:0]  cab_b
);

    typedef struct packed {
        logic [15:0] dipsw;
        logic [ 6:0] joystick1;
        logic [ 6:0] joystick2;
        logic [ 1:0] coin;
        logic        service;
        logic [ 1:0] cab_1p;
    } cab_t;

    cab_t sync1, sync2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= {dipsw, joystick1, joystick2, coin, service, cab_1p};
            sync2 <= sync1;
        end
    end

    assign cab_a[0] = sync2.dipsw[ 7:0];
    assign cab_a[1] = sync2.dipsw[15:8];
    assign cab_b[0] = {sync2.coin, sync2.service, sync2.joystick1[4:0]};
    assign cab_b[1] = {sync2.cab_1p, sync2.joystick2[5:0]};

endmodule

// File: flist.f
snd_pkg.sv
snd_decode.sv
cab_inputs.sv
wsg_ram.sv
wsg_timer.sv
wsg_seq.sv
snd_board.sv
snd_check.sv
snd_tb.sv

// File: snd_board.sv
/* sound board top, ties decoder, cabinet inputs, wave ram, timer and sequencer
   NVOICE and SAMPLE_DIV are set here and passed down */
`timescale 1ns/10ps

module snd_board #(
    parameter int NVOICE     = 4,
    parameter int SAMPLE_DIV = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  logic              bus_sel,     // 1 main bus owns the wave ram
    input  snd_pkg::snd_bus_t snd_bus,
    input  snd_pkg::mbus_t    main_bus,
    input  logic              lvbl,
    input  logic [15:0]       dipsw,
    input  logic [ 6:0]       joystick1,
    input  logic [ 6:0]       joystick2,
    input  logic [ 1:0]       coin,
    input  logic              service,
    input  logic [ 1:0]       cab_1p,
    output snd_pkg::byte_t    rdata,
    output logic              rd_valid,
    output snd_pkg::byte_t    c30_dout,
    output logic              c30_valid,
    output logic              irq,
    output snd_pkg::sample_t  snd,
    output logic              snd_valid
);

    snd_pkg::byte_t [1:0] cab_a, cab_b;
    snd_pkg::mbus_t       wram_req;
    snd_pkg::byte_t       wram_rdata;
    snd_pkg::maddr_t      voice_addr;
    snd_pkg::byte_t       voice_data;
    logic                 tick;

    snd_decode u_decode (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .bus        ( snd_bus     ),
        .lvbl       ( lvbl        ),
        .cab_a      ( cab_a       ),
        .cab_b      ( cab_b       ),
        .wram_rdata ( wram_rdata  ),
        .wram_req   ( wram_req    ),
        .rdata      ( rdata       ),
        .rd_valid   ( rd_valid    ),
        .irq        ( irq         )
    );

    cab_inputs u_cab (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .dipsw      ( dipsw       ),
        .joystick1  ( joystick1   ),
        .joystick2  ( joystick2   ),
        .coin       ( coin        ),
        .service    ( service     ),
        .cab_1p     ( cab_1p      ),
        .cab_a      ( cab_a       ),
        .cab_b      ( cab_b       )
    );

    wsg_ram u_ram (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .bus_sel    ( bus_sel     ),
        .snd_req    ( wram_req    ),
        .main_req   ( main_bus    ),
        .voice_addr ( voice_addr  ),
        .snd_rdata  ( wram_rdata  ),
        .main_rdata ( c30_dout    ),
        .c30_valid  ( c30_valid   ),
        .voice_data ( voice_data  )
    );

    wsg_timer #(.SAMPLE_DIV(SAMPLE_DIV)) u_timer (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .cen        ( cen         ),
        .tick       ( tick        )
    );

    wsg_seq #(.NVOICE(NVOICE)) u_seq (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .tick       ( tick        ),
        .voice_data ( voice_data  ),
        .voice_addr ( voice_addr  ),
        .snd        ( snd         ),
        .snd_valid  ( snd_valid   )
    );

endmodule

// File: snd_cases.txt
# op sel wr addr data exp, all hex; sel is bus_sel, data is the skip count for S
# W/R sound bus, M main bus, V vblank edge (wr=1 adds an ack), K irq ack, C cabinet, S sample
W 0 1 1200 5a 0
R 0 0 1200 0 5a
M 1 0 200 0 5a
M 0 1 200 33 0
R 0 0 1200 0 5a
R 1 0 1200 0 0
M 1 1 201 c3 0
M 1 0 201 0 c3
M 0 0 201 0 0
R 0 0 1201 0 c3
C 0 0 12a5 1122d15 0
R 0 0 2020 0 a5
R 0 0 2021 0 12
R 0 0 2030 0 b5
R 0 0 2031 0 6d
R 0 0 4000 0 0
V 0 0 0 0 1
K 0 1 0 0 0
V 0 1 0 0 1
K 0 1 3ff 0 0
W 0 1 1100 00 0
W 0 1 1101 80 0
W 0 1 1102 05 0
W 0 1 1103 00 0
W 0 1 1104 00 0
W 0 1 1105 00 0
W 0 1 1106 00 0
W 0 1 1107 00 0
W 0 1 1108 00 0
W 0 1 1109 00 0
W 0 1 110a 00 0
W 0 1 110b 00 0
W 0 1 110c 00 0
W 0 1 110d 00 0
W 0 1 110e 00 0
W 0 1 110f 00 0
W 0 1 1000 3a 0
W 0 1 1001 f1 0
S 0 0 0 0 00a
S 0 0 0 0 fe7
S 0 0 0 0 fdd
S 0 0 0 0 023
W 0 1 1101 00 0
W 0 1 1000 00 0
W 0 1 1002 00 0
W 0 1 1102 0f 0
W 0 1 1106 0f 0
W 0 1 110a 0f 0
W 0 1 110e 0f 0
S 0 0 0 1 e20
S 0 0 0 0 e20

// File: snd_check.sv
/* response checker for the sound board testbench
   compare tasks are called by snd_tb, sample spacing is watched here */
`timescale 1ns/10ps

module snd_check #(
    parameter int SAMPLE_DIV = 64
) (
    input logic             clk,
    input logic             rst_n,
    input snd_pkg::byte_t   rdata,
    input logic             rd_valid,
    input snd_pkg::byte_t   c30_dout,
    input logic             c30_valid,
    input logic             irq,
    input snd_pkg::sample_t snd,
    input logic             snd_valid
);

    int errors = 0;
    int checks = 0;
    int cyc, last_cyc;
    bit seen;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic compare_rd(input logic [31:0] exp);
        compare("sound bus read", {24'd0, rdata}, {24'd0, exp[7:0]});
    endtask

    task automatic compare_main(input logic [31:0] exp);
        compare("main bus read", {24'd0, c30_dout}, {24'd0, exp[7:0]});
    endtask

    task automatic compare_irq(input logic [31:0] exp);
        compare("irq", {31'd0, irq}, {31'd0, exp[0]});
    endtask

    task automatic compare_snd(input logic [31:0] exp);
        compare("mixed sample", {20'd0, snd}, {20'd0, exp[11:0]});   // 12-bit two's complement
    endtask

    task automatic missing(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic summary();
        $display("checks %0d errors %0d", checks, errors);
    endtask

    // cen never stops once started, so samples come exactly one timer period apart
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc  <= 0;
            seen <= 1'b0;
        end else begin
            cyc <= cyc + 1;
            if (snd_valid) begin
                if (seen)
                    compare("sample spacing", 32'(cyc - last_cyc), 32'(SAMPLE_DIV * 4));
                seen     <= 1'b1;
                last_cyc <= cyc;
            end
        end
    end

endmodule

// File: snd_decode.sv
/* sound cpu address decoder with registered read mux and vblank interrupt latch
   read data and rd_valid come one clock after the bus strobe */
`timescale 1ns/10ps

module snd_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  snd_pkg::snd_bus_t     bus,
    input  logic                  lvbl,
    input  snd_pkg::byte_t [1:0]  cab_a,
    input  snd_pkg::byte_t [1:0]  cab_b,
    input  snd_pkg::byte_t        wram_rdata,
    output snd_pkg::mbus_t        wram_req,
    output snd_pkg::byte_t        rdata,
    output logic                  rd_valid,
    output logic                  irq
);

    logic           wram_cs, porta_cs, portb_cs, ack_cs;
    logic           wram_rd_q;      // read was aimed at the wave ram
    snd_pkg::byte_t port_q;         // 0 for unmapped reads
    logic           lvbl_q;
    logic           vb_fall;

    always_comb begin
        wram_cs  = bus.strobe && bus.addr[15:10] == snd_pkg::WRAM_BASE[15:10];
        porta_cs = bus.strobe && !bus.wr && bus.addr[15:12] == snd_pkg::PORT_BASE[15:12]
                   && bus.addr[5:4] == snd_pkg::PORT_A_SEL;
        portb_cs = bus.strobe && !bus.wr && bus.addr[15:12] == snd_pkg::PORT_BASE[15:12]
                   && bus.addr[5:4] == snd_pkg::PORT_B_SEL;
        ack_cs   = bus.strobe && bus.wr && bus.addr[15:12] == snd_pkg::IRQ_ACK_BASE[15:12];
    end

    always_comb begin
        wram_req.strobe = wram_cs;
        wram_req.wr     = bus.wr;
        wram_req.addr   = bus.addr[9:0];    // offset inside the window
        wram_req.wdata  = bus.wdata;
    end

    always_ff @(posedge clk) begin
        port_q <= porta_cs ? cab_a[bus.addr[0]] :
                  portb_cs ? cab_b[bus.addr[0]] : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            wram_rd_q <= 1'b0;
        end else begin
            rd_valid  <= bus.strobe && !bus.wr;
            wram_rd_q <= wram_cs && !bus.wr;
        end
    end

    assign rdata = wram_rd_q ? wram_rdata : port_q;    // ram data is already registered

    assign vb_fall = lvbl_q && !lvbl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvbl_q <= 1'b1;
            irq    <= 1'b0;
        end else begin
            lvbl_q <= lvbl;
            if (vb_fall)
                irq <= 1'b1;        // set beats a simultaneous ack
            else if (ack_cs)
                irq <= 1'b0;
        end
    end

    a_one_select: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({wram_cs, porta_cs, portb_cs, ack_cs}));

endmodule

// File: snd_pkg.sv
/* shared widths, bus structs, voice register layout and address map of the sound board
   referenced by scoped name, never imported */
package snd_pkg;

    typedef logic        [15:0] addr_t;    // sound cpu address
    typedef logic        [ 9:0] maddr_t;   // main bus and wave ram offset
    typedef logic        [ 7:0] byte_t;
    typedef logic signed [11:0] sample_t;
    typedef logic        [15:0] freq_t;
    typedef logic        [19:0] phase_t;   // top 5 bits index the 32-sample wave

    typedef struct packed {
        logic  strobe;
        logic  wr;
        addr_t addr;
        byte_t wdata;
    } snd_bus_t;

    typedef struct packed {
        logic   strobe;
        logic   wr;
        maddr_t addr;
        byte_t  wdata;
    } mbus_t;

    typedef struct packed {
        freq_t      freq;
        logic [3:0] wave;      // waveform number in the low 3 bits
        logic [3:0] vol;
    } voice_regs_t;

    typedef enum logic [2:0] {
        IDLE, FREQ_LO, FREQ_HI, VOL, WAVE, NIBBLE, ACCUM, DONE
    } seq_state_e;

    // sound cpu memory map
    localparam addr_t      WRAM_BASE    = 16'h1000;   // 1 KB window
    localparam addr_t      PORT_BASE    = 16'h2000;
    localparam addr_t      IRQ_ACK_BASE = 16'hb000;   // writes only
    localparam logic [1:0] PORT_A_SEL   = 2'd2;       // A[5:4]
    localparam logic [1:0] PORT_B_SEL   = 2'd3;

    // 4 bytes per voice from here: freq lo, freq hi, volume, wave
    localparam maddr_t     VOICE_BASE   = 10'h100;

endpackage

// File: snd_tb.sv
/* sound board testbench, reads snd_cases.txt and drives the sound and main buses
   snd_check does the comparing, this module prints the final verdict */
`timescale 1ns/10ps

module snd_tb;

    localparam int NVOICE     = 4;
    localparam int SAMPLE_DIV = 64;
    localparam int MAX_CASES  = 128;

    logic              clk = 1'b0;
    logic              rst_n, cen, cen_run, bus_sel, lvbl, service;
    snd_pkg::snd_bus_t snd_bus;
    snd_pkg::mbus_t    main_bus;
    logic [15:0]       dipsw;
    logic [ 6:0]       joystick1, joystick2;
    logic [ 1:0]       coin, cab_1p;
    snd_pkg::byte_t    rdata, c30_dout;
    logic              rd_valid, c30_valid, irq, snd_valid;
    snd_pkg::sample_t  snd;
    logic [ 1:0]       cen_cnt;

    // one entry per case line
    logic [ 7:0] op_q   [MAX_CASES];
    logic [31:0] f_sel  [MAX_CASES];
    logic [31:0] f_wr   [MAX_CASES];
    logic [31:0] f_addr [MAX_CASES];
    logic [31:0] f_data [MAX_CASES];
    logic [31:0] f_exp  [MAX_CASES];
    int          ncases;
    int          cycles = 0;
    int          limit  = 0;
    bit          loaded;

    snd_board #(.NVOICE(NVOICE), .SAMPLE_DIV(SAMPLE_DIV)) i_snd_board (
        .clk(clk), .rst_n(rst_n), .cen(cen), .bus_sel(bus_sel),
        .snd_bus(snd_bus), .main_bus(main_bus), .lvbl(lvbl),
        .dipsw(dipsw), .joystick1(joystick1), .joystick2(joystick2),
        .coin(coin), .service(service), .cab_1p(cab_1p),
        .rdata(rdata), .rd_valid(rd_valid), .c30_dout(c30_dout),
        .c30_valid(c30_valid), .irq(irq), .snd(snd), .snd_valid(snd_valid)
    );

    snd_check #(.SAMPLE_DIV(SAMPLE_DIV)) u_check (
        .clk(clk), .rst_n(rst_n), .rdata(rdata), .rd_valid(rd_valid),
        .c30_dout(c30_dout), .c30_valid(c30_valid), .irq(irq),
        .snd(snd), .snd_valid(snd_valid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cen_cnt <= cen_cnt + 1'b1;
        cen     <= cen_run && cen_cnt == 2'd3;     // every 4th cycle once samples run
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles, run did not finish", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic load_cases(output bit ok);
        int                fd;
        int                code;
        logic [63:0]       tok;
        logic [8*128-1:0]  line;
        ok     = 1'b0;
        ncases = 0;
        fd     = $fopen("snd_cases.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd) && ncases < MAX_CASES) begin
                tok  = '0;
                code = $fscanf(fd, "%s", tok);
                if (code == 1) begin
                    if (tok[7:0] == "#") begin
                        code = $fgets(line, fd);    // rest of a comment line
                    end else begin
                        code = $fscanf(fd, "%h %h %h %h %h", f_sel[ncases], f_wr[ncases],
                                       f_addr[ncases], f_data[ncases], f_exp[ncases]);
                        op_q[ncases] = tok[7:0];
                        ncases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic snd_access(input logic sel, input logic wr, input logic [31:0] addr,
                              input logic [31:0] data);
        @(posedge clk);
        bus_sel <= sel;
        snd_bus <= '{strobe: 1'b1, wr: wr, addr: addr[15:0], wdata: data[7:0]};
        @(posedge clk);
        snd_bus <= '0;
    endtask

    task automatic main_access(input logic sel, input logic wr, input logic [31:0] addr,
                               input logic [31:0] data);
        @(posedge clk);
        bus_sel  <= sel;
        main_bus <= '{strobe: 1'b1, wr: wr, addr: addr[9:0], wdata: data[7:0]};
        @(posedge clk);
        main_bus <= '0;
    endtask

    task automatic wait_sample(output bit got);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!snd_valid && n < 3 * SAMPLE_DIV * 4);
        got = snd_valid;
    endtask

    task automatic run_case(input int i);
        bit got;
        case (op_q[i])
            "W": snd_access(f_sel[i][0], 1'b1, f_addr[i], f_data[i]);
            "R": begin
                snd_access(f_sel[i][0], 1'b0, f_addr[i], '0);
                @(posedge clk);                     // data is due one cycle after the strobe
                if (rd_valid)
                    u_check.compare_rd(f_exp[i]);
                else
                    u_check.missing("no rd_valid one cycle after a sound bus read");
            end
            "M": begin
                main_access(f_sel[i][0], f_wr[i][0], f_addr[i], f_data[i]);
                if (!f_wr[i][0]) begin
                    @(posedge clk);
                    if (c30_valid)
                        u_check.compare_main(f_exp[i]);
                    else
                        u_check.missing("no c30_valid one cycle after a main bus read");
                end
            end
            "V", "K": begin
                @(posedge clk);
                bus_sel <= f_sel[i][0];
                if (op_q[i] == "V")
                    lvbl <= 1'b0;
                if (op_q[i] == "K" || f_wr[i][0])   // ack in the same cycle as the edge
                    snd_bus <= '{strobe: 1'b1, wr: 1'b1, addr: 16'hb000 | f_addr[i][15:0],
                                 wdata: 8'h00};
                @(posedge clk);
                lvbl    <= 1'b1;
                snd_bus <= '0;
                @(posedge clk);
                u_check.compare_irq(f_exp[i]);
            end
            "C": begin
                @(posedge clk);
                dipsw     <= f_addr[i][15:0];
                joystick1 <= f_data[i][6:0];
                joystick2 <= f_data[i][14:8];
                coin      <= f_data[i][17:16];
                service   <= f_data[i][20];
                cab_1p    <= f_data[i][25:24];
                repeat (3) @(posedge clk);          // synchronizer delay
            end
            "S": begin
                cen_run <= 1'b1;
                got = 1'b1;
                for (int k = 0; k <= int'(f_data[i]) && got; k++)
                    wait_sample(got);
                if (got)
                    u_check.compare_snd(f_exp[i]);
                else
                    u_check.missing("no snd_valid within three sample periods");
            end
            default: u_check.missing("unknown operation in the cases file");
        endcase
    endtask

    initial begin
        rst_n     = 1'b0;
        cen       = 1'b0;
        cen_run   = 1'b0;
        cen_cnt   = '0;
        bus_sel   = 1'b0;
        snd_bus   = '0;
        main_bus  = '0;
        lvbl      = 1'b1;
        dipsw     = '0;
        joystick1 = '0;
        joystick2 = '0;
        coin      = '0;
        service   = 1'b0;
        cab_1p    = '0;
        void'($urandom(32'h087b_600e));
        load_cases(loaded);
        limit = ncases * (NVOICE * 6 + 2 + SAMPLE_DIV * 4) + 1000;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        if (!loaded) begin
            $display("could not open snd_cases.txt");
            $display("CHECKS FAILED");
        end else begin
            for (int i = 0; i < ncases; i++) begin
                repeat ($urandom % 3) @(posedge clk);   // idle gap
                run_case(i);
            end
            u_check.summary();
            if (u_check.errors == 0)
                $display("ALL CHECKS PASSED");
            else
                $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: wsg_ram.sv
/* 1 KB wave ram, bus port owned by main (bus_sel=1) or sound cpu (bus_sel=0)
   voice port reads every cycle for the sequencer, one clock latency */
`timescale 1ns/10ps

module wsg_ram (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            bus_sel,
    input  snd_pkg::mbus_t  snd_req,
    input  snd_pkg::mbus_t  main_req,
    input  snd_pkg::maddr_t voice_addr,
    output snd_pkg::byte_t  snd_rdata,
    output snd_pkg::byte_t  main_rdata,
    output logic            c30_valid,
    output snd_pkg::byte_t  voice_data
);

    snd_pkg::byte_t mem [1024];
    snd_pkg::mbus_t req;            // owning bus
    snd_pkg::byte_t rd_q;
    logic           snd_hit_q, main_hit_q;
    logic           we;

    assign req = bus_sel ? main_req : snd_req;
    assign we  = req.strobe && req.wr;

    always_ff @(posedge clk) begin
        if (we)
            mem[req.addr] <= req.wdata;
        rd_q       <= mem[req.addr];
        voice_data <= mem[voice_addr];  // old data on a same-cycle write
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_hit_q  <= 1'b0;
            main_hit_q <= 1'b0;
            c30_valid  <= 1'b0;
        end else begin
            snd_hit_q  <= !bus_sel && snd_req.strobe && !snd_req.wr;
            main_hit_q <= bus_sel && main_req.strobe && !main_req.wr;
            c30_valid  <= main_req.strobe && !main_req.wr;  // given even when ignored
        end
    end

    assign snd_rdata  = snd_hit_q  ? rd_q : '0;
    assign main_rdata = main_hit_q ? rd_q : '0;

    // ignored writes leave the addressed byte untouched
    a_snd_ignored: assert property (@(posedge clk) disable iff (!rst_n)
        bus_sel && snd_req.strobe && snd_req.wr && !(we && req.addr == snd_req.addr)
        |=> mem[$past(snd_req.addr)] == $past(mem[snd_req.addr]));

    a_main_ignored: assert property (@(posedge clk) disable iff (!rst_n)
        !bus_sel && main_req.strobe && main_req.wr && !(we && req.addr == main_req.addr)
        |=> mem[$past(main_req.addr)] == $past(mem[main_req.addr]));

endmodule

// File: wsg_seq.sv
/* wavetable sequencer, on each tick walks all voices through the wave ram voice port
   and mixes them into one saturated sample, 6 cycles per voice */
`timescale 1ns/10ps

module wsg_seq #(
    parameter int NVOICE = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  snd_pkg::byte_t   voice_data,
    output snd_pkg::maddr_t  voice_addr,
    output snd_pkg::sample_t snd,
    output logic             snd_valid
);

    localparam int VW   = NVOICE > 1 ? $clog2(NVOICE) : 1;
    localparam int SW   = $bits(snd_pkg::sample_t);
    localparam int ACCW = SW + VW + 1;
    localparam logic signed [ACCW-1:0] SMAX = 2**(SW-1) - 1;
    localparam logic signed [ACCW-1:0] SMIN = -(2**(SW-1));

    snd_pkg::seq_state_e    state;
    logic [VW-1:0]          vidx, vnext;
    snd_pkg::voice_regs_t   regs;
    snd_pkg::phase_t        phase [NVOICE];
    snd_pkg::phase_t        cur_phase;
    logic signed [ACCW-1:0] acc;
    logic [3:0]             nib;
    logic signed [4:0]      centered;
    logic signed [9:0]      contrib;
    snd_pkg::sample_t       sat;

    assign cur_phase = phase[vidx];
    assign vnext     = state == snd_pkg::ACCUM ? vidx + 1'b1 : '0;

    // address goes out one cycle ahead of the state that takes the data
    always_comb begin
        case (state)
            snd_pkg::IDLE,
            snd_pkg::ACCUM:   voice_addr = snd_pkg::VOICE_BASE + {vnext, 2'd0};
            snd_pkg::FREQ_LO: voice_addr = snd_pkg::VOICE_BASE + {vidx, 2'd1};
            snd_pkg::FREQ_HI: voice_addr = snd_pkg::VOICE_BASE + {vidx, 2'd2};
            snd_pkg::VOL:     voice_addr = snd_pkg::VOICE_BASE + {vidx, 2'd3};
            snd_pkg::NIBBLE:  voice_addr = {3'd0, regs.wave[2:0], cur_phase[19:16]};
            default:          voice_addr = snd_pkg::VOICE_BASE;
        endcase
    end

    always_ff @(posedge clk) begin
        case (state)
            snd_pkg::FREQ_LO: regs.freq[ 7:0] <= voice_data;
            snd_pkg::FREQ_HI: regs.freq[15:8] <= voice_data;
            snd_pkg::VOL:     regs.vol  <= voice_data[3:0];
            snd_pkg::WAVE:    regs.wave <= voice_data[3:0];
            default: ;
        endcase
    end

    assign nib      = cur_phase[15] ? voice_data[7:4] : voice_data[3:0]; // low nibble first
    assign centered = $signed({1'b0, nib}) - 5'sd8;
    assign contrib  = centered * $signed({1'b0, regs.vol});

    always_comb begin
        if (acc > SMAX)
            sat = snd_pkg::sample_t'(SMAX);
        else if (acc < SMIN)
            sat = snd_pkg::sample_t'(SMIN);
        else
            sat = snd_pkg::sample_t'(acc);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= snd_pkg::IDLE;
            vidx      <= '0;
            acc       <= '0;
            snd       <= '0;
            snd_valid <= 1'b0;
            for (int i = 0; i < NVOICE; i++)
                phase[i] <= '0;
        end else begin
            snd_valid <= 1'b0;
            case (state)
                snd_pkg::IDLE: if (tick) begin     // ticks elsewhere are dropped
                    acc   <= '0;
                    vidx  <= '0;
                    state <= snd_pkg::FREQ_LO;
                end
                snd_pkg::FREQ_LO: state <= snd_pkg::FREQ_HI;
                snd_pkg::FREQ_HI: state <= snd_pkg::VOL;
                snd_pkg::VOL:     state <= snd_pkg::WAVE;
                snd_pkg::WAVE:    state <= snd_pkg::NIBBLE;
                snd_pkg::NIBBLE:  state <= snd_pkg::ACCUM;
                snd_pkg::ACCUM: begin
                    acc         <= acc + contrib;
                    phase[vidx] <= cur_phase + snd_pkg::phase_t'(regs.freq);
                    if (vidx == VW'(NVOICE - 1)) begin
                        state <= snd_pkg::DONE;
                    end else begin
                        vidx  <= vidx + 1'b1;
                        state <= snd_pkg::FREQ_LO;
                    end
                end
                snd_pkg::DONE: begin
                    snd       <= sat;
                    snd_valid <= 1'b1;
                    vidx      <= '0;
                    state     <= snd_pkg::IDLE;
                end
                default: state <= snd_pkg::IDLE;
            endcase
        end
    end

    a_vidx_range: assert property (@(posedge clk) disable iff (!rst_n)
        state != snd_pkg::IDLE && state != snd_pkg::DONE |-> int'(vidx) < NVOICE);

    // sample comes out a fixed delay after an accepted tick
    a_sweep_len: assert property (@(posedge clk) disable iff (!rst_n)
        state == snd_pkg::IDLE && tick |-> ##(NVOICE * 6 + 2) snd_valid);

endmodule

// File: wsg_timer.sv
/* sample rate timer, one tick every SAMPLE_DIV clock enables */
`timescale 1ns/10ps

module wsg_timer #(
    parameter int SAMPLE_DIV = 64
) (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,
    output logic tick
);

    localparam int CW = SAMPLE_DIV > 1 ? $clog2(SAMPLE_DIV) : 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (cen) begin
                if (cnt == CW'(SAMPLE_DIV - 1)) begin
                    cnt  <= '0;
                    tick <= 1'b1;   // single cycle strobe
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule
